// File: filelist.f
+incdir+tb
hdl/memPkg.sv
hdl/bankSteer.sv
hdl/memBank.sv
hdl/respOrder.sv
hdl/memSubsystem.sv
tb/tbMemSubsystem.sv

// File: hdl/bankSteer.sv
// Request buffer and bank steering
`default_nettype none
`timescale 1ns/1ns

module bankSteer #(
  parameter int NUM_BANKS   = memPkg::DEF_NUM_BANKS,
  parameter int BANK_WORDS  = memPkg::DEF_BANK_WORDS,
  parameter int REQ_CREDITS = memPkg::DEF_REQ_CREDITS,
  parameter int BANK_DEPTH  = memPkg::DEF_BANK_DEPTH
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          reqValid,
  input  logic                          reqWrite,
  input  memPkg::addrT                  reqAddr,
  input  memPkg::dataT                  reqData,
  input  memPkg::maskT                  reqMask,
  input  logic [NUM_BANKS-1:0]          bankCredit,
  input  logic                          orderFull,
  output logic                          reqCredit,
  output logic [NUM_BANKS-1:0]          bankValid,
  output logic                          bankWrite,
  output logic [$clog2(BANK_WORDS)-1:0] bankRow,
  output memPkg::dataT                  bankData,
  output memPkg::maskT                  bankMask,
  output logic                          orderPush,
  output logic [$clog2(NUM_BANKS)-1:0]  orderBank
);
  import memPkg::*;

  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W  = $clog2(BANK_WORDS);
  localparam int PTR_W  = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
  localparam int FCNT_W = $clog2(REQ_CREDITS + 1);
  localparam int BCNT_W = $clog2(BANK_DEPTH + 1);

  // Request FIFO
  logic              fWrite [REQ_CREDITS];
  addrT              fAddr  [REQ_CREDITS];
  dataT              fData  [REQ_CREDITS];
  maskT              fMask  [REQ_CREDITS];
  logic [PTR_W-1:0]  wrPtr;
  logic [PTR_W-1:0]  rdPtr;
  logic [FCNT_W-1:0] fCount;

  // Free slots in each bank queue
  logic [BCNT_W-1:0] bankCnt [NUM_BANKS];

  logic              headWrite;
  addrT              headAddr;
  logic [BANK_W-1:0] headBank;
  logic              fire;

  assign headWrite = fWrite[rdPtr];
  assign headAddr  = fAddr[rdPtr];
  // Low word-address bits interleave over the banks
  assign headBank  = headAddr[BANK_W-1:0];

  // Reads also need room in the order queue
  assign fire = (fCount != '0) && (bankCnt[headBank] != '0) && (headWrite || !orderFull);

  assign reqCredit = fire;
  assign bankValid = fire ? (NUM_BANKS'(1) << headBank) : '0;
  assign bankWrite = headWrite;
  assign bankRow   = headAddr[BANK_W +: ROW_W];
  assign bankData  = fData[rdPtr];
  assign bankMask  = fMask[rdPtr];
  assign orderPush = fire && !headWrite;
  assign orderBank = headBank;

  always_ff @(posedge clk)
  begin
    if (reqValid)
    begin
      fWrite[wrPtr] <= reqWrite;
      fAddr[wrPtr]  <= reqAddr;
      fData[wrPtr]  <= reqData;
      fMask[wrPtr]  <= reqMask;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      fCount <= '0;
      for (int i = 0; i < NUM_BANKS; i++)
        bankCnt[i] <= BCNT_W'(BANK_DEPTH);
    end
    else
    begin
      if (reqValid)
        wrPtr <= (wrPtr == PTR_W'(REQ_CREDITS - 1)) ? '0 : wrPtr + 1'b1;
      if (fire)
        rdPtr <= (rdPtr == PTR_W'(REQ_CREDITS - 1)) ? '0 : rdPtr + 1'b1;
      fCount <= fCount + FCNT_W'(reqValid) - FCNT_W'(fire);
      // Spend on send, refill on bank dequeue
      for (int i = 0; i < NUM_BANKS; i++)
        bankCnt[i] <= bankCnt[i] + BCNT_W'(bankCredit[i]) - BCNT_W'(bankValid[i]);
    end
  end

  // Requester never sends without a credit
  assert property (@(posedge clk) disable iff (rst)
    reqValid |-> fCount < FCNT_W'(REQ_CREDITS));

  for (genvar g = 0; g < NUM_BANKS; g++)
  begin : gCntChk
    // Banks return no more credits than were spent
    assert property (@(posedge clk) disable iff (rst)
      bankCnt[g] <= BCNT_W'(BANK_DEPTH));
  end

endmodule

`default_nettype wire

// File: hdl/memBank.sv
// Interleaved RAM bank
`default_nettype none
`timescale 1ns/1ns

module memBank #(
  parameter int BANK_WORDS = memPkg::DEF_BANK_WORDS,
  parameter int BANK_DEPTH = memPkg::DEF_BANK_DEPTH
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          bankValid,
  input  logic                          bankWrite,
  input  logic [$clog2(BANK_WORDS)-1:0] bankRow,
  input  memPkg::dataT                  bankData,
  input  memPkg::maskT                  bankMask,
  input  logic                          rdPop,
  output logic                          bankCredit,
  output logic                          rdValid,
  output memPkg::dataT                  rdData
);
  import memPkg::*;

  localparam int ROW_W = $clog2(BANK_WORDS);
  localparam int PTR_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
  localparam int CNT_W = $clog2(BANK_DEPTH + 1);

  // Request queue
  logic             qWrite [BANK_DEPTH];
  logic [ROW_W-1:0] qRow   [BANK_DEPTH];
  dataT             qData  [BANK_DEPTH];
  maskT             qMask  [BANK_DEPTH];
  logic [PTR_W-1:0] qWrPtr;
  logic [PTR_W-1:0] qRdPtr;
  logic [CNT_W-1:0] qCount;

  // Storage and read stage
  dataT             ram [BANK_WORDS];
  dataT             ramQ;
  logic             rdPend;

  // Response buffer
  dataT             respBuf [BANK_DEPTH];
  logic [PTR_W-1:0] rWrPtr;
  logic [PTR_W-1:0] rRdPtr;
  logic [CNT_W-1:0] rCount;

  logic             headWrite;
  logic [ROW_W-1:0] headRow;
  dataT             headData;
  maskT             headMask;
  logic             respRoom;
  logic             deq;

  assign headWrite = qWrite[qRdPtr];
  assign headRow   = qRow[qRdPtr];
  assign headData  = qData[qRdPtr];
  assign headMask  = qMask[qRdPtr];

  // A read in the RAM stage already owns a response slot
  assign respRoom = (rCount + CNT_W'(rdPend)) < CNT_W'(BANK_DEPTH);
  assign deq      = (qCount != '0) && (headWrite || respRoom);

  assign bankCredit = deq;
  assign rdValid    = rCount != '0;
  assign rdData     = respBuf[rRdPtr];

  always_ff @(posedge clk)
  begin
    if (bankValid)
    begin
      qWrite[qWrPtr] <= bankWrite;
      qRow[qWrPtr]   <= bankRow;
      qData[qWrPtr]  <= bankData;
      qMask[qWrPtr]  <= bankMask;
    end
    if (rdPend)
      respBuf[rWrPtr] <= ramQ;
  end

  // Byte-masked write, registered read
  always_ff @(posedge clk)
  begin
    if (deq && headWrite)
    begin
      for (int b = 0; b < $bits(maskT); b++)
      begin
        if (headMask[b])
          ram[headRow][8*b +: 8] <= headData[8*b +: 8];
      end
    end
    ramQ <= ram[headRow];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      qWrPtr <= '0;
      qRdPtr <= '0;
      qCount <= '0;
      rdPend <= 1'b0;
      rWrPtr <= '0;
      rRdPtr <= '0;
      rCount <= '0;
    end
    else
    begin
      if (bankValid)
        qWrPtr <= (qWrPtr == PTR_W'(BANK_DEPTH - 1)) ? '0 : qWrPtr + 1'b1;
      if (deq)
        qRdPtr <= (qRdPtr == PTR_W'(BANK_DEPTH - 1)) ? '0 : qRdPtr + 1'b1;
      qCount <= qCount + CNT_W'(bankValid) - CNT_W'(deq);
      rdPend <= deq && !headWrite;
      if (rdPend)
        rWrPtr <= (rWrPtr == PTR_W'(BANK_DEPTH - 1)) ? '0 : rWrPtr + 1'b1;
      if (rdPop)
        rRdPtr <= (rRdPtr == PTR_W'(BANK_DEPTH - 1)) ? '0 : rRdPtr + 1'b1;
      rCount <= rCount + CNT_W'(rdPend) - CNT_W'(rdPop);
    end
  end

  // Steer side must respect the bank credits
  assert property (@(posedge clk) disable iff (rst)
    bankValid |-> qCount < CNT_W'(BANK_DEPTH));

  // Order logic pops only what is present
  assert property (@(posedge clk) disable iff (rst) rdPop |-> rdValid);

endmodule

`default_nettype wire

// File: hdl/memPkg.sv
// Memory subsystem shared types
`default_nettype none

package memPkg;

  // Word address as seen by the requester
  typedef logic [15:0] addrT;

  // One data word
  typedef logic [31:0] dataT;

  // Byte enables with bit i covering byte i of the word
  typedef logic [3:0] maskT;

  // Bank count as a power of two
  localparam int DEF_NUM_BANKS = 4;

  // Words held by each bank
  localparam int DEF_BANK_WORDS = 256;

  // Requester credits, equal to the steer FIFO depth
  localparam int DEF_REQ_CREDITS = 4;

  // Depth of each bank request queue and response buffer
  localparam int DEF_BANK_DEPTH = 2;

endpackage

`default_nettype wire

// File: hdl/memSubsystem.sv
// Banked memory subsystem top
`default_nettype none
`timescale 1ns/1ns

module memSubsystem #(
  parameter int NUM_BANKS   = memPkg::DEF_NUM_BANKS,
  parameter int BANK_WORDS  = memPkg::DEF_BANK_WORDS,
  parameter int REQ_CREDITS = memPkg::DEF_REQ_CREDITS,
  parameter int BANK_DEPTH  = memPkg::DEF_BANK_DEPTH
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         reqValid,
  input  logic         reqWrite,
  input  memPkg::addrT reqAddr,
  input  memPkg::dataT reqData,
  input  memPkg::maskT reqMask,
  input  logic         respCredit,
  output logic         reqCredit,
  output logic         respValid,
  output memPkg::dataT respData
);
  import memPkg::*;

  // Steer to bank request links
  logic [NUM_BANKS-1:0]          bankValid;
  logic [NUM_BANKS-1:0]          bankCredit;
  logic                          bankWrite;
  logic [$clog2(BANK_WORDS)-1:0] bankRow;
  dataT                          bankData;
  maskT                          bankMask;

  // Read order entries
  logic                          orderPush;
  logic [$clog2(NUM_BANKS)-1:0]  orderBank;
  logic                          orderFull;

  // Bank response buffers
  logic [NUM_BANKS-1:0]          rdValid;
  logic [NUM_BANKS-1:0]          rdPop;
  dataT [NUM_BANKS-1:0]          rdData;

  bankSteer #(
    .NUM_BANKS  (NUM_BANKS  ),
    .BANK_WORDS (BANK_WORDS ),
    .REQ_CREDITS(REQ_CREDITS),
    .BANK_DEPTH (BANK_DEPTH )
  ) u_bankSteer (
    .clk       (clk       ),
    .rst       (rst       ),
    .reqValid  (reqValid  ),
    .reqWrite  (reqWrite  ),
    .reqAddr   (reqAddr   ),
    .reqData   (reqData   ),
    .reqMask   (reqMask   ),
    .bankCredit(bankCredit),
    .orderFull (orderFull ),
    .reqCredit (reqCredit ),
    .bankValid (bankValid ),
    .bankWrite (bankWrite ),
    .bankRow   (bankRow   ),
    .bankData  (bankData  ),
    .bankMask  (bankMask  ),
    .orderPush (orderPush ),
    .orderBank (orderBank )
  );

  for (genvar i = 0; i < NUM_BANKS; i++)
  begin : gBank
    memBank #(
      .BANK_WORDS(BANK_WORDS),
      .BANK_DEPTH(BANK_DEPTH)
    ) u_memBank (
      .clk       (clk          ),
      .rst       (rst          ),
      .bankValid (bankValid[i] ),
      .bankWrite (bankWrite    ),
      .bankRow   (bankRow      ),
      .bankData  (bankData     ),
      .bankMask  (bankMask     ),
      .rdPop     (rdPop[i]     ),
      .bankCredit(bankCredit[i]),
      .rdValid   (rdValid[i]   ),
      .rdData    (rdData[i]    )
    );
  end

  respOrder #(
    .NUM_BANKS  (NUM_BANKS  ),
    .REQ_CREDITS(REQ_CREDITS),
    .BANK_DEPTH (BANK_DEPTH )
  ) u_respOrder (
    .clk       (clk       ),
    .rst       (rst       ),
    .orderPush (orderPush ),
    .orderBank (orderBank ),
    .rdValid   (rdValid   ),
    .rdData    (rdData    ),
    .respCredit(respCredit),
    .orderFull (orderFull ),
    .rdPop     (rdPop     ),
    .respValid (respValid ),
    .respData  (respData  )
  );

endmodule

`default_nettype wire

// File: hdl/respOrder.sv
// In-order read response return
`default_nettype none
`timescale 1ns/1ns

module respOrder #(
  parameter int NUM_BANKS   = memPkg::DEF_NUM_BANKS,
  parameter int REQ_CREDITS = memPkg::DEF_REQ_CREDITS,
  parameter int BANK_DEPTH  = memPkg::DEF_BANK_DEPTH
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            orderPush,
  input  logic [$clog2(NUM_BANKS)-1:0]    orderBank,
  input  logic [NUM_BANKS-1:0]            rdValid,
  input  memPkg::dataT [NUM_BANKS-1:0]    rdData,
  input  logic                            respCredit,
  output logic                            orderFull,
  output logic [NUM_BANKS-1:0]            rdPop,
  output logic                            respValid,
  output memPkg::dataT                    respData
);
  import memPkg::*;

  localparam int BANK_W      = $clog2(NUM_BANKS);
  // Covers every read that can sit between the steer FIFO and the banks
  localparam int ORDER_DEPTH = REQ_CREDITS + NUM_BANKS * BANK_DEPTH;
  localparam int PTR_W       = $clog2(ORDER_DEPTH);
  localparam int CNT_W       = $clog2(ORDER_DEPTH + 1);
  localparam int CRED_W      = 16;

  // Bank index of each outstanding read, oldest at the read pointer
  logic [BANK_W-1:0] orderBuf [ORDER_DEPTH];
  logic [PTR_W-1:0]  oWrPtr;
  logic [PTR_W-1:0]  oRdPtr;
  logic [CNT_W-1:0]  oCount;

  // Response slots granted by the consumer
  logic [CRED_W-1:0] credCnt;

  logic [BANK_W-1:0] headBank;
  dataT              headData;
  logic              headReady;

  assign headBank  = orderBuf[oRdPtr];
  assign headData  = rdData[headBank];
  assign headReady = (oCount != '0) && rdValid[headBank] && (credCnt != '0);

  assign orderFull = oCount == CNT_W'(ORDER_DEPTH);
  assign rdPop     = headReady ? (NUM_BANKS'(1) << headBank) : '0;

  always_ff @(posedge clk)
  begin
    if (orderPush)
      orderBuf[oWrPtr] <= orderBank;
    if (headReady)
      respData <= headData;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      oWrPtr    <= '0;
      oRdPtr    <= '0;
      oCount    <= '0;
      credCnt   <= '0;
      respValid <= 1'b0;
    end
    else
    begin
      if (orderPush)
        oWrPtr <= (oWrPtr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : oWrPtr + 1'b1;
      if (headReady)
        oRdPtr <= (oRdPtr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : oRdPtr + 1'b1;
      oCount    <= oCount + CNT_W'(orderPush) - CNT_W'(headReady);
      credCnt   <= credCnt + CRED_W'(respCredit) - CRED_W'(headReady);
      respValid <= headReady;
    end
  end

  // Steer side never pushes into a full order queue
  assert property (@(posedge clk) disable iff (rst)
    orderPush |-> !orderFull);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module tbMemSubsystem -o simMem > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build did not complete, see build.log"
  exit 1
fi

./obj_dir/simMem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  echo "No result line found in sim.log"
  exit 1
fi
exit 0

// File: tb/memTests.svh
// Memory subsystem directed tests
`ifndef MEM_TESTS_SVH
`define MEM_TESTS_SVH

function automatic logic [31:0] nextRand();
  rngState = rngState ^ (rngState << 13);
  rngState = rngState ^ (rngState >> 17);
  rngState = rngState ^ (rngState << 5);
  return rngState;
endfunction

// Bytes with a set mask bit take the new data
function automatic dataT mergeBytes(input dataT old, input dataT nw, input maskT m);
  dataT r;
  r = old;
  for (int b = 0; b < 4; b++)
  begin
    if (m[b])
      r[8*b +: 8] = nw[8*b +: 8];
  end
  return r;
endfunction

// Sample outputs of the cycle just ended
task automatic observe();
  // A credit pulse frees its slot only at the next rising edge
  if (creditSeen)
    credits++;
  creditSeen = reqCredit;
  if (credits > REQ_CREDITS)
    reportFault("more request credits returned than were spent");
  if (respValid)
  begin
    grantsOut--;
    if (grantsOut < 0)
      reportFault("response sent without a granted response credit");
    if (expQ.size() == 0)
      reportFault("response arrived with no read outstanding");
    else
      checkEq(respData, expQ.pop_front(), "read data");
    respCount++;
  end
endtask

task automatic advance();
  logic [31:0] r;
  @(negedge clk);
  observe();
  reqValid   = 1'b0;
  respCredit = 1'b0;
  if (grantOnce)
  begin
    respCredit = 1'b1;
    grantOnce  = 1'b0;
  end
  else if (grantMode == 1 && grantsOut < expQ.size())
    respCredit = 1'b1;
  else if (grantMode == 2 && grantsOut < expQ.size())
  begin
    r = nextRand();
    respCredit = r[0];
  end
  if (respCredit)
    grantsOut++;
endtask

task automatic driveReq(input logic w, input int a, input dataT d, input maskT m);
  reqValid = 1'b1;
  reqWrite = w;
  reqAddr  = addrT'(a);
  reqData  = d;
  reqMask  = m;
  credits--;
  if (w)
    refMem[a] = mergeBytes(refMem[a], d, m);
  else
    expQ.push_back(refMem[a]);
endtask

task automatic sendReq(input logic w, input int a, input dataT d, input maskT m);
  int t;
  t = 0;
  advance();
  while (credits == 0 && t < TIMEOUT)
  begin
    advance();
    t++;
  end
  if (credits == 0)
    timedOut("no request credit came back");
  else
    driveReq(w, a, d, m);
endtask

// Until every read answered and every credit home
task automatic drain();
  int t;
  t = 0;
  grantMode = 1;
  advance();
  while ((expQ.size() != 0 || credits != REQ_CREDITS) && t < TIMEOUT)
  begin
    advance();
    t++;
  end
  if (expQ.size() != 0 || credits != REQ_CREDITS)
    timedOut("responses or request credits did not return");
endtask

task automatic idleAfterReset();
  for (int i = 0; i < 10; i++)
  begin
    advance();
    checkEq(32'(reqCredit), 32'd0, "reqCredit while idle");
    checkEq(32'(respValid), 32'd0, "respValid while idle");
  end
endtask

task automatic fullWordReadback();
  grantMode = 1;
  for (int a = 0; a < TEST_WORDS; a++)
    sendReq(1'b1, a, nextRand(), 4'hF);
  for (int a = 0; a < TEST_WORDS; a++)
    sendReq(1'b0, a, '0, '0);
  drain();
endtask

task automatic partialWriteMerge();
  grantMode = 1;
  for (int m = 1; m < 16; m++)
  begin
    sendReq(1'b1, 21, 32'ha5c3_9617, 4'hF);
    sendReq(1'b1, 21, nextRand(), maskT'(m));
    sendReq(1'b0, 21, '0, '0);
  end
  drain();
endtask

task automatic inOrderReturn();
  grantMode = 1;
  // Two passes over all banks and then bank 2 over and over
  for (int i = 0; i < 16; i++)
    sendReq(1'b0, (i < 8) ? i : 4 * i + 2, '0, '0);
  drain();
endtask

task automatic backPressureStall();
  int issued;
  int quiet;
  int t;
  int start;
  issued    = 0;
  quiet     = 0;
  t         = 0;
  grantMode = 0;
  while (quiet < 20 && t < 400)
  begin
    advance();
    t++;
    checkEq(32'(respValid), 32'd0, "respValid without credit");
    quiet = reqCredit ? 0 : quiet + 1;
    if (credits > 0)
    begin
      driveReq(1'b0, issued, '0, '0);
      issued++;
      quiet = 0;
    end
  end
  if (quiet < 20)
    reportFault("reqCredit kept coming under back-pressure");
  // Order queue plus request buffer
  checkEq(issued, 2 * REQ_CREDITS + NUM_BANKS * BANK_DEPTH, "reads accepted before stall");
  start = respCount;
  for (int k = 0; k < issued; k++)
  begin
    grantOnce = 1'b1;
    advance();
    t = 0;
    while (respCount - start == k && t < TIMEOUT)
    begin
      advance();
      t++;
    end
    if (respCount - start == k)
      timedOut("no response after a credit grant");
    repeat (2) advance();
  end
  checkEq(respCount - start, issued, "responses after grants");
  drain();
endtask

task automatic randomTraffic();
  logic [31:0] r;
  grantMode = 2;
  for (int i = 0; i < 200; i++)
  begin
    r = nextRand();
    sendReq(r[6], int'(r & 32'd63), nextRand(), r[10:7]);
  end
  drain();
endtask

`endif

// File: tb/tbMemSubsystem.sv
// Memory subsystem testbench
`default_nettype none
`timescale 1ns/1ns

module tbMemSubsystem;
  import memPkg::*;

  localparam int NUM_BANKS   = DEF_NUM_BANKS;
  localparam int BANK_WORDS  = DEF_BANK_WORDS;
  localparam int REQ_CREDITS = DEF_REQ_CREDITS;
  localparam int BANK_DEPTH  = DEF_BANK_DEPTH;
  // Address window covered by the reference model
  localparam int TEST_WORDS  = 64;
  localparam int TIMEOUT     = 200;

  logic clk;
  logic rst;
  logic reqValid;
  logic reqWrite;
  addrT reqAddr;
  dataT reqData;
  maskT reqMask;
  logic respCredit;
  logic reqCredit;
  logic respValid;
  dataT respData;

  // Requester credits held and response slots granted but unused
  int          credits;
  bit          creditSeen;
  int          grantsOut;
  int          respCount;
  int          errCount;
  int          toCount;
  // 0 no grants, 1 grant while reads wait, 2 random grants
  int          grantMode;
  bit          grantOnce;
  logic [31:0] rngState;
  dataT        refMem [TEST_WORDS];
  dataT        expQ [$];

  memSubsystem #(
    .NUM_BANKS  (NUM_BANKS  ),
    .BANK_WORDS (BANK_WORDS ),
    .REQ_CREDITS(REQ_CREDITS),
    .BANK_DEPTH (BANK_DEPTH )
  ) u_memSubsystem (
    .clk       (clk       ),
    .rst       (rst       ),
    .reqValid  (reqValid  ),
    .reqWrite  (reqWrite  ),
    .reqAddr   (reqAddr   ),
    .reqData   (reqData   ),
    .reqMask   (reqMask   ),
    .respCredit(respCredit),
    .reqCredit (reqCredit ),
    .respValid (respValid ),
    .respData  (respData  )
  );

  always #4 clk = ~clk;

  task automatic checkEq(input dataT got, input dataT exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      errCount++;
    end
  endtask

  task automatic reportFault(input string what);
    $display("Failure at %0t: %s", $time, what);
    errCount++;
  endtask

  task automatic timedOut(input string what);
    $display("Timeout at %0t: %s", $time, what);
    toCount++;
  endtask

  `include "memTests.svh"

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    reqValid   = 1'b0;
    reqWrite   = 1'b0;
    reqAddr    = '0;
    reqData    = '0;
    reqMask    = '0;
    respCredit = 1'b0;
    credits    = REQ_CREDITS;
    creditSeen = 1'b0;
    grantsOut  = 0;
    respCount  = 0;
    errCount   = 0;
    toCount    = 0;
    grantMode  = 0;
    grantOnce  = 1'b0;
    rngState   = 32'h3bf21606;
    // Three rising edges in reset
    repeat (3) @(negedge clk);
    rst = 1'b0;
    idleAfterReset();
    fullWordReadback();
    partialWriteMerge();
    inOrderReturn();
    backPressureStall();
    randomTraffic();
    $display("Errors: %0d, timeouts: %0d", errCount, toCount);
    if (errCount == 0 && toCount == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
